/* hdl/uart_consts.svh */
/*
 * UART widths, control register bit positions and word addresses.
 * Included by the package and by every module that needs a constant.
 */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

`define UART_DATA_W    8   // character width
`define UART_BAUD_W    10  // baud divisor width
`define UART_PRSC_W    3   // prescaler select width
`define UART_CLKGEN_W  8   // clkgen strobe taps
`define UART_BUS_W     32  // bus data width
`define UART_TX_BITS   11  // start + 8 data + stop + pause
`define UART_RX_BITS   10  // start + 8 data + stop

// word addresses, addr_i[3:2]
`define UART_ADDR_CTRL 0
`define UART_ADDR_DATA 1

// --------------------
// control / status bit positions, bit 1 reserved
`define UART_BIT_EN             0
`define UART_BIT_HWFC           2
`define UART_BIT_PRSC           3   // lsb of prescaler select
`define UART_BIT_BAUD           6   // lsb of baud divisor
`define UART_BIT_RX_NEMPTY      16
`define UART_BIT_RX_HALF        17
`define UART_BIT_RX_FULL        18
`define UART_BIT_TX_EMPTY       19
`define UART_BIT_TX_NHALF       20
`define UART_BIT_TX_FULL        21
`define UART_BIT_IRQ_RX_NEMPTY  22
`define UART_BIT_IRQ_RX_HALF    23
`define UART_BIT_IRQ_RX_FULL    24
`define UART_BIT_IRQ_TX_EMPTY   25
`define UART_BIT_IRQ_TX_NHALF   26
`define UART_BIT_RX_OVER        30
`define UART_BIT_TX_BUSY        31

`endif

/* hdl/uart_pkg.sv */
/*
 * Shared types of the UART: payload vectors and the engine state encodings.
 */
`include "uart_consts.svh"

package uart_pkg;

    typedef logic [`UART_DATA_W-1:0] uart_byte_t;  // one character
    typedef logic [`UART_BAUD_W-1:0] baud_t;       // divisor or bit-time count
    typedef logic [`UART_PRSC_W-1:0] prsc_t;       // clkgen tap select
    typedef logic [`UART_BUS_W-1:0]  bus_word_t;   // host data word
    typedef logic [3:0]              bitcnt_t;     // bits left in a frame

    typedef enum logic [1:0] {
        TX_OFF,
        TX_IDLE,
        TX_PREPARE,
        TX_SEND
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_OFF,
        RX_IDLE,
        RX_RECEIVE
    } rx_state_e;

endpackage

/* hdl/uart_rx.sv */
/*
 * Receive engine. Synchronizes rxd, waits for a start bit and samples
 * each bit mid-way; done_o pulses once per received frame.
 */
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_rx (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               enable_i,     // engine on
    input  logic               baud_tick_i,  // prescaled strobe
    input  uart_pkg::baud_t    baud_i,       // bit time - 1
    input  logic               rxd_i,        // serial line, async
    output uart_pkg::uart_byte_t data_o,
    output logic               done_o        // frame received
);
    import uart_pkg::*;

    rx_state_e                  state;
    logic [2:0]                 sync;      // [2] first stage, [1:0] edge pair
    baud_t                      baud_cnt;
    bitcnt_t                    bit_cnt;
    logic [`UART_RX_BITS-1:0]   sreg;      // stop, data, start

    // --------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state    <= RX_OFF;
            sync     <= '1;                          // line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
            done_o   <= 1'b0;
        end else begin
            sync[2] <= rxd_i;
            if (baud_tick_i) begin                   // slow stages filter glitches
                sync[1] <= sync[2];
                sync[0] <= sync[1];
            end
            done_o <= 1'b0;

            if (!enable_i) begin
                state <= RX_OFF;
            end else begin
                case (state)
                    RX_IDLE: begin
                        baud_cnt <= baud_i >> 1;     // half bit, sample mid-bit
                        bit_cnt  <= bitcnt_t'(`UART_RX_BITS);
                        if (sync[1:0] == 2'b01) begin // falling edge = start bit
                            state <= RX_RECEIVE;
                        end
                    end
                    RX_RECEIVE: begin
                        if (baud_tick_i) begin
                            if (baud_cnt == '0) begin    // sample point
                                baud_cnt <= baud_i;
                                bit_cnt  <= bit_cnt - 1'b1;
                                sreg     <= {sync[2], sreg[`UART_RX_BITS-1:1]};
                            end else begin
                                baud_cnt <= baud_cnt - 1'b1;
                            end
                        end
                        if (bit_cnt == '0) begin         // all bits in
                            done_o <= 1'b1;
                            state  <= RX_IDLE;
                        end
                    end
                    default: state <= RX_IDLE;           // leaving OFF
                endcase
            end
        end
    end

    assign data_o = sreg[`UART_DATA_W:1];  // drop start and stop bits

endmodule

/* hdl/uart_fifo.sv */
/*
 * Byte FIFO with registered read data. DEPTH must be a power of two, at
 * least 2. Writes when full and reads when empty are ignored.
 */
`timescale 1ns/1ns

module uart_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 clear_i,   // sync flush
    input  logic                 we_i,
    input  logic                 re_i,
    input  uart_pkg::uart_byte_t wdata_i,
    output uart_pkg::uart_byte_t rdata_o,   // head entry, one cycle late
    output logic                 free_o,    // not full
    output logic                 avail_o,   // not empty
    output logic                 half_o     // at least DEPTH/2 held
);
    import uart_pkg::*;

    localparam int AW = $clog2(DEPTH);

    uart_byte_t  mem [DEPTH];
    logic [AW:0] wr_ptr, rd_ptr;   // extra msb tells full from empty
    logic [AW:0] level;
    logic        full, empty;

    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty   = (wr_ptr == rd_ptr);
    assign level   = wr_ptr - rd_ptr;
    assign free_o  = ~full;
    assign avail_o = ~empty;
    assign half_o  = (level >= (AW+1)'(DEPTH/2));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (we_i && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (re_i && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage and read port
    always_ff @(posedge clk_i) begin
        if (we_i && !full) begin
            mem[wr_ptr[AW-1:0]] <= wdata_i;
        end
        rdata_o <= mem[rd_ptr[AW-1:0]];
    end

endmodule

/* hdl/uart_regs.sv */
/*
 * Register block: control word and data word decode, status readback,
 * interrupts, overrun flag, RTS and baud tick select. Writes ack after
 * one cycle, reads after two.
 */
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_regs (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic [3:0]                 addr_i,       // byte address
    input  logic                       wren_i,
    input  logic                       rden_i,
    input  uart_pkg::bus_word_t        data_i,
    output uart_pkg::bus_word_t        data_o,
    output logic                       ack_o,
    input  logic [`UART_CLKGEN_W-1:0]  clkgen_i,
    output logic                       clkgen_en_o,
    output logic                       baud_tick_o,
    output uart_pkg::baud_t            baud_o,
    output logic                       enable_o,
    output logic                       fifo_clear_o,
    output logic                       tx_we_o,
    output uart_pkg::uart_byte_t       tx_wdata_o,
    input  logic                       tx_free_i,
    input  logic                       tx_avail_i,
    input  logic                       tx_half_i,
    input  logic                       tx_busy_i,
    output logic                       rx_re_o,
    input  uart_pkg::uart_byte_t       rx_rdata_i,
    input  logic                       rx_free_i,
    input  logic                       rx_avail_i,
    input  logic                       rx_half_i,
    input  logic                       rx_done_i,    // rx fifo write strobe
    output logic                       hwfc_en_o,
    output logic                       uart_rts_o,
    output logic                       irq_rx_o,
    output logic                       irq_tx_o
);
    import uart_pkg::*;

    logic       sel_ctrl, sel_data;
    logic       rden_ff, rd_ctrl_ff;   // read delayed for fifo latency
    logic       enable, hwfc_en;
    prsc_t      prsc;
    baud_t      baud;
    logic [4:0] irq_en;                // tx_nhalf .. rx_nempty
    logic       rx_over;

    assign sel_ctrl = (addr_i[3:2] == 2'(`UART_ADDR_CTRL));
    assign sel_data = (addr_i[3:2] == 2'(`UART_ADDR_DATA));

    // --------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            enable  <= 1'b0;
            hwfc_en <= 1'b0;
            prsc    <= '0;
            baud    <= '0;
            irq_en  <= '0;
        end else if (wren_i && sel_ctrl) begin
            enable  <= data_i[`UART_BIT_EN];
            hwfc_en <= data_i[`UART_BIT_HWFC];
            prsc    <= data_i[`UART_BIT_PRSC +: `UART_PRSC_W];
            baud    <= data_i[`UART_BIT_BAUD +: `UART_BAUD_W];
            irq_en  <= data_i[`UART_BIT_IRQ_RX_NEMPTY +: 5];
        end
    end

    // readback, one cycle after the fifo has its head registered
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rden_ff    <= 1'b0;
            rd_ctrl_ff <= 1'b0;
            ack_o      <= 1'b0;
            data_o     <= '0;
        end else begin
            rden_ff    <= rden_i;
            rd_ctrl_ff <= sel_ctrl;
            ack_o      <= wren_i | rden_ff;
            data_o     <= '0;
            if (rden_ff && rd_ctrl_ff) begin
                data_o[`UART_BIT_EN]                       <= enable;
                data_o[`UART_BIT_HWFC]                     <= hwfc_en;
                data_o[`UART_BIT_PRSC +: `UART_PRSC_W]     <= prsc;
                data_o[`UART_BIT_BAUD +: `UART_BAUD_W]     <= baud;
                data_o[`UART_BIT_RX_NEMPTY]                <= rx_avail_i;
                data_o[`UART_BIT_RX_HALF]                  <= rx_half_i;
                data_o[`UART_BIT_RX_FULL]                  <= ~rx_free_i;
                data_o[`UART_BIT_TX_EMPTY]                 <= ~tx_avail_i;
                data_o[`UART_BIT_TX_NHALF]                 <= ~tx_half_i;
                data_o[`UART_BIT_TX_FULL]                  <= ~tx_free_i;
                data_o[`UART_BIT_IRQ_RX_NEMPTY +: 5]       <= irq_en;
                data_o[`UART_BIT_RX_OVER]                  <= rx_over;
                data_o[`UART_BIT_TX_BUSY]                  <= tx_busy_i | tx_avail_i;
            end else if (rden_ff) begin
                data_o[`UART_DATA_W-1:0] <= rx_rdata_i;        // data word
            end
        end
    end

    // --------------------
    // irqs, overrun and rts, all one cycle behind their condition
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            irq_rx_o   <= 1'b0;
            irq_tx_o   <= 1'b0;
            rx_over    <= 1'b0;
            uart_rts_o <= 1'b0;
        end else begin
            irq_rx_o <= enable & ((irq_en[0] & rx_avail_i) |
                                  (irq_en[1] & rx_half_i)  |
                                  (irq_en[2] & ~rx_free_i));
            irq_tx_o <= enable & ((irq_en[3] & ~tx_avail_i) |
                                  (irq_en[4] & ~tx_half_i));
            if (rx_re_o || !enable) begin
                rx_over <= 1'b0;                       // data read clears
            end else if (rx_done_i && !rx_free_i) begin
                rx_over <= 1'b1;                       // byte lost
            end
            uart_rts_o <= hwfc_en & (~enable | rx_half_i);  // high = stop sending
        end
    end

    assign tx_we_o      = wren_i & sel_data;
    assign tx_wdata_o   = data_i[`UART_DATA_W-1:0];
    assign rx_re_o      = rden_i & sel_data;           // pop in the request cycle
    assign clkgen_en_o  = enable;
    assign enable_o     = enable;
    assign fifo_clear_o = ~enable;
    assign hwfc_en_o    = hwfc_en;
    assign baud_o       = baud;
    assign baud_tick_o  = clkgen_i[prsc];

endmodule

/* hdl/uart_tx.sv */
/*
 * Transmit engine. Pops one byte from the TX FIFO, waits for CTS when
 * flow control is on, then sends start, data, stop and a pause bit.
 */
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_tx (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 enable_i,
    input  logic                 baud_tick_i,
    input  uart_pkg::baud_t      baud_i,
    input  logic                 hwfc_en_i,
    input  logic                 cts_i,          // low = peer ready
    input  logic                 fifo_avail_i,
    input  uart_pkg::uart_byte_t fifo_rdata_i,   // valid one cycle after the pop
    output logic                 fifo_re_o,
    output logic                 busy_o,
    output logic                 txd_o
);
    import uart_pkg::*;

    tx_state_e                state;
    logic [1:0]               cts_sync;
    logic                     pop_q;      // popped byte on fifo_rdata_i now
    baud_t                    baud_cnt;
    bitcnt_t                  bit_cnt;
    logic [`UART_DATA_W:0]    sreg;       // data and start bit

    // --------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state    <= TX_OFF;
            cts_sync <= 2'b11;                           // not clear to send
            pop_q    <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            cts_sync <= {cts_sync[0], cts_i};
            pop_q    <= fifo_re_o;
            if (!enable_i) begin
                state <= TX_OFF;
            end else begin
                case (state)
                    TX_IDLE: begin
                        baud_cnt <= baud_i;
                        bit_cnt  <= bitcnt_t'(`UART_TX_BITS);
                        if (fifo_avail_i) begin
                            state <= TX_PREPARE;          // pop issued this cycle
                        end
                    end
                    TX_PREPARE: begin
                        if (!cts_sync[1] || !hwfc_en_i) begin
                            state <= TX_SEND;
                        end
                    end
                    TX_SEND: begin
                        if (baud_tick_i) begin
                            if (baud_cnt == '0) begin     // bit time over
                                baud_cnt <= baud_i;
                                bit_cnt  <= bit_cnt - 1'b1;
                            end else begin
                                baud_cnt <= baud_cnt - 1'b1;
                            end
                        end
                        if (bit_cnt == '0) begin
                            state <= TX_IDLE;
                        end
                    end
                    default: state <= TX_IDLE;            // leaving OFF
                endcase
            end
        end
    end

    // ones shifted in give the stop and pause bits
    always_ff @(posedge clk_i) begin
        if (pop_q) begin
            sreg <= {fifo_rdata_i, 1'b0};                 // first PREPARE cycle only
        end else if (state == TX_SEND && baud_tick_i && baud_cnt == '0) begin
            sreg <= {1'b1, sreg[`UART_DATA_W:1]};
        end
    end

    assign fifo_re_o = (state == TX_IDLE) & fifo_avail_i;
    assign busy_o    = (state == TX_PREPARE) | (state == TX_SEND);
    assign txd_o     = (state == TX_SEND) ? sreg[0] : 1'b1;   // lsb first

endmodule

/* hdl/uart_top.sv */
/*
 * UART top level. Receive engine, RX and TX FIFOs, register block and
 * transmit engine along the serial path.
 */
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_top #(
    parameter int RX_FIFO_DEPTH = 4,   // power of two, min 2
    parameter int TX_FIFO_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic [3:0]                addr_i,
    input  logic                      rden_i,
    input  logic                      wren_i,
    input  uart_pkg::bus_word_t       data_i,
    output uart_pkg::bus_word_t       data_o,
    output logic                      ack_o,
    output logic                      clkgen_en_o,
    input  logic [`UART_CLKGEN_W-1:0] clkgen_i,
    output logic                      uart_txd_o,
    input  logic                      uart_rxd_i,
    output logic                      uart_rts_o,
    input  logic                      uart_cts_i,
    output logic                      irq_rx_o,
    output logic                      irq_tx_o
);
    import uart_pkg::*;

    logic       baud_tick, enable, fifo_clear, hwfc_en;
    baud_t      baud;
    uart_byte_t rx_data, rx_rdata, tx_wdata, tx_rdata;
    logic       rx_done, rx_re, rx_free, rx_avail, rx_half;
    logic       tx_we, tx_re, tx_free, tx_avail, tx_half, tx_busy;

    // --------------------
    // input side
    uart_rx u_rx (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .enable_i(enable), .baud_tick_i(baud_tick), .baud_i(baud),
        .rxd_i(uart_rxd_i), .data_o(rx_data), .done_o(rx_done)
    );

    uart_fifo #(.DEPTH(RX_FIFO_DEPTH)) u_rx_fifo (
        .clk_i(clk_i), .rstn_i(rstn_i), .clear_i(fifo_clear),
        .we_i(rx_done), .re_i(rx_re), .wdata_i(rx_data), .rdata_o(rx_rdata),
        .free_o(rx_free), .avail_o(rx_avail), .half_o(rx_half)
    );

    uart_regs u_regs (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .addr_i(addr_i), .wren_i(wren_i), .rden_i(rden_i),
        .data_i(data_i), .data_o(data_o), .ack_o(ack_o),
        .clkgen_i(clkgen_i), .clkgen_en_o(clkgen_en_o), .baud_tick_o(baud_tick),
        .baud_o(baud), .enable_o(enable), .fifo_clear_o(fifo_clear),
        .tx_we_o(tx_we), .tx_wdata_o(tx_wdata), .tx_free_i(tx_free),
        .tx_avail_i(tx_avail), .tx_half_i(tx_half), .tx_busy_i(tx_busy),
        .rx_re_o(rx_re), .rx_rdata_i(rx_rdata), .rx_free_i(rx_free),
        .rx_avail_i(rx_avail), .rx_half_i(rx_half), .rx_done_i(rx_done),
        .hwfc_en_o(hwfc_en), .uart_rts_o(uart_rts_o),
        .irq_rx_o(irq_rx_o), .irq_tx_o(irq_tx_o)
    );

    // --------------------
    // output side
    uart_fifo #(.DEPTH(TX_FIFO_DEPTH)) u_tx_fifo (
        .clk_i(clk_i), .rstn_i(rstn_i), .clear_i(fifo_clear),
        .we_i(tx_we), .re_i(tx_re), .wdata_i(tx_wdata), .rdata_o(tx_rdata),
        .free_o(tx_free), .avail_o(tx_avail), .half_o(tx_half)
    );

    uart_tx u_tx (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .enable_i(enable), .baud_tick_i(baud_tick), .baud_i(baud),
        .hwfc_en_i(hwfc_en), .cts_i(uart_cts_i),
        .fifo_avail_i(tx_avail), .fifo_rdata_i(tx_rdata),
        .fifo_re_o(tx_re), .busy_o(tx_busy), .txd_o(uart_txd_o)
    );

endmodule

/* tests/tb_uart.sv */
/*
 * Self-checking testbench for the UART top level. TX is looped back to RX;
 * the control word, bytes and expected status come from tests/uart_vectors.txt.
 */
`timescale 1ns/1ns
`include "uart_consts.svh"

module tb_uart;

    localparam int RX_DEPTH = 4;

    logic        clk_i = 1'b0;
    logic        rstn_i = 1'b0;
    logic [3:0]  addr_i = '0;
    logic        rden_i = 1'b0;
    logic        wren_i = 1'b0;
    logic [31:0] data_i = '0;
    logic [31:0] data_o;
    logic        ack_o, clkgen_en_o, uart_txd_o, uart_rts_o, irq_rx_o, irq_tx_o;
    logic [7:0]  clkgen_i = '0;
    logic        uart_cts_i = 1'b0;
    logic [7:0]  gen_cnt = '0;               // free counter for clkgen taps

    int          mismatches = 0;
    int          failures = 0;               // non-value errors
    int          cycles = 0;
    int          limit = 1000000;            // replaced once vectors are known
    logic [31:0] ctrl_word, exp_stat, rd;
    logic [7:0]  bytes [$];

    uart_top #(.RX_FIFO_DEPTH(RX_DEPTH), .TX_FIFO_DEPTH(4)) u_uart_top (
        .clk_i(clk_i), .rstn_i(rstn_i), .addr_i(addr_i), .rden_i(rden_i),
        .wren_i(wren_i), .data_i(data_i), .data_o(data_o), .ack_o(ack_o),
        .clkgen_en_o(clkgen_en_o), .clkgen_i(clkgen_i), .uart_txd_o(uart_txd_o),
        .uart_rxd_i(uart_txd_o), .uart_rts_o(uart_rts_o), .uart_cts_i(uart_cts_i),
        .irq_rx_o(irq_rx_o), .irq_tx_o(irq_tx_o)
    );

    initial begin
        forever #2 clk_i = ~clk_i;           // 4 ns period
    end

    // tap k pulses once every 2^k cycles
    always @(negedge clk_i) begin
        logic [7:0] nxt;
        nxt = gen_cnt + 1'b1;
        gen_cnt <= nxt;
        for (int k = 0; k < 8; k++) begin
            clkgen_i[k] <= ((nxt & ((8'd1 << k) - 1'b1)) == 8'd0);
        end
    end

    // --------------------
    task automatic end_run();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run did not complete within %0d cycles", limit);
            failures++;
            end_run();
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic bus_write(input logic [1:0] word, input logic [31:0] val);
        @(negedge clk_i);
        addr_i = {word, 2'b00};
        data_i = val;
        wren_i = 1'b1;
        @(negedge clk_i);
        wren_i = 1'b0;
        check_val("ack_o (write)", ack_o, 1);   // one cycle after wren_i
    endtask

    task automatic bus_read(input logic [1:0] word, output logic [31:0] val);
        @(negedge clk_i);
        addr_i = {word, 2'b00};
        rden_i = 1'b1;
        @(negedge clk_i);
        rden_i = 1'b0;
        check_val("ack_o (read, early)", ack_o, 0);
        @(negedge clk_i);
        check_val("ack_o (read)", ack_o, 1);     // two cycles after rden_i
        val = data_o;
    endtask

    // poll the control word until a status bit takes a value
    task automatic wait_bit(input int pos, input logic val);
        logic [31:0] st;
        st = ~{32{val}};
        while (st[pos] !== val) begin
            bus_read(`UART_ADDR_CTRL, st);
        end
    endtask

    task automatic read_byte(input logic [7:0] exp);
        logic [31:0] got;
        bus_read(`UART_ADDR_DATA, got);
        check_val("data_o (rx byte)", got, {24'h0, exp});
    endtask

    task automatic load_vectors();
        int    fd;
        string line, tag;
        logic [31:0] val;
        fd = $fopen("tests/uart_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            failures++;
            end_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 2 && line[0] != "#" &&
                    $sscanf(line, "%s %h", tag, val) == 2) begin
                    if (tag == "ctrl") ctrl_word = val;
                    else if (tag == "byte") bytes.push_back(val[7:0]);
                    else if (tag == "stat") exp_stat = val;
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------
    initial begin
        load_vectors();
        limit = bytes.size() * 11 * (ctrl_word[15:6] + 1) * (1 << ctrl_word[5:3]) * 2
                + 2000;
        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;

        // reset values
        check_val("ack_o", ack_o, 0);
        check_val("irq_rx_o", irq_rx_o, 0);
        check_val("irq_tx_o", irq_tx_o, 0);
        check_val("uart_rts_o", uart_rts_o, 0);
        check_val("clkgen_en_o", clkgen_en_o, 0);
        check_val("uart_txd_o", uart_txd_o, 1);
        bus_read(`UART_ADDR_CTRL, rd);
        check_val("ctrl after reset", rd, 32'h0018_0000);  // tx fifo empty

        // r/w fields with bit 1 set, which must read 0
        bus_write(`UART_ADDR_CTRL, 32'h07C0_FFFF);
        check_val("clkgen_en_o", clkgen_en_o, 1);
        bus_read(`UART_ADDR_CTRL, rd);
        check_val("ctrl readback", rd, 32'h07D8_FFFD);
        bus_write(`UART_ADDR_CTRL, 32'h0);
        check_val("clkgen_en_o", clkgen_en_o, 0);

        // loopback one byte at a time
        bus_write(`UART_ADDR_CTRL, ctrl_word);
        bus_read(`UART_ADDR_CTRL, rd);
        check_val("ctrl readback", rd, ctrl_word | (1 << `UART_BIT_TX_EMPTY) |
                  (1 << `UART_BIT_TX_NHALF));
        foreach (bytes[i]) begin
            bus_write(`UART_ADDR_DATA, {24'h0, bytes[i]});
            wait_bit(`UART_BIT_RX_NEMPTY, 1'b1);
            read_byte(bytes[i]);
        end

        // interrupts
        bus_write(`UART_ADDR_CTRL, ctrl_word | (1 << `UART_BIT_IRQ_TX_EMPTY) |
                  (1 << `UART_BIT_IRQ_RX_NEMPTY));
        repeat (2) @(negedge clk_i);
        check_val("irq_tx_o", irq_tx_o, 1);
        check_val("irq_rx_o", irq_rx_o, 0);
        bus_write(`UART_ADDR_DATA, {24'h0, bytes[0]});
        while (irq_rx_o !== 1'b1) @(negedge clk_i);
        read_byte(bytes[0]);
        repeat (2) @(negedge clk_i);
        check_val("irq_rx_o", irq_rx_o, 0);

        // --------------------
        // overrun with one byte more than the rx fifo holds
        bus_write(`UART_ADDR_CTRL, ctrl_word);
        for (int i = 0; i <= RX_DEPTH; i++) begin
            bus_write(`UART_ADDR_DATA, {24'h0, bytes[i]});
            wait_bit(`UART_BIT_TX_EMPTY, 1'b1);
        end
        wait_bit(`UART_BIT_RX_OVER, 1'b1);
        wait_bit(`UART_BIT_TX_BUSY, 1'b0);
        bus_read(`UART_ADDR_CTRL, rd);
        check_val("status after overrun", rd & 32'hC03F_0000, exp_stat);
        for (int i = 0; i < RX_DEPTH; i++) begin
            read_byte(bytes[i]);
            if (i == 0) begin
                bus_read(`UART_ADDR_CTRL, rd);
                check_val("RX_OVER", rd[`UART_BIT_RX_OVER], 0);
            end
        end

        // cts high holds the byte back
        bus_write(`UART_ADDR_CTRL, 32'h0);
        uart_cts_i = 1'b1;
        bus_write(`UART_ADDR_CTRL, ctrl_word | (1 << `UART_BIT_HWFC));
        bus_write(`UART_ADDR_DATA, {24'h0, bytes[1]});
        repeat (100) begin
            @(negedge clk_i);
            check_val("uart_txd_o", uart_txd_o, 1);
        end
        bus_read(`UART_ADDR_CTRL, rd);
        check_val("TX_BUSY", rd[`UART_BIT_TX_BUSY], 1);
        uart_cts_i = 1'b0;
        wait_bit(`UART_BIT_RX_NEMPTY, 1'b1);
        read_byte(bytes[1]);

        // rts while rx fifo is half full
        for (int i = 0; i < RX_DEPTH / 2; i++) begin
            bus_write(`UART_ADDR_DATA, {24'h0, bytes[i]});
        end
        wait_bit(`UART_BIT_RX_HALF, 1'b1);
        repeat (2) @(negedge clk_i);
        check_val("uart_rts_o", uart_rts_o, 1);
        read_byte(bytes[0]);
        repeat (2) @(negedge clk_i);
        check_val("uart_rts_o", uart_rts_o, 0);

        end_run();
    end

endmodule

/* tests/uart_vectors.txt */
# tag value(hex): ctrl = control word, byte = loopback byte,
# stat = expected status bits 31:30,21:16 after the overrun test
ctrl c9
byte 55
byte a3
byte 00
byte ff
byte 3c
byte 81
byte 7e
byte 12
stat 401f0000

/* verilog.f */
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_rx.sv
hdl/uart_fifo.sv
hdl/uart_regs.sv
hdl/uart_tx.sv
hdl/uart_top.sv
tests/tb_uart.sv

/* Bender.yml */
package:
  name: uart

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/uart_pkg.sv
      - hdl/uart_rx.sv
      - hdl/uart_fifo.sv
      - hdl/uart_regs.sv
      - hdl/uart_tx.sv
      - hdl/uart_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_uart.sv
